// ==== source/cache_be_cfg.svh ====
`ifndef CACHE_BE_CFG_SVH
`define CACHE_BE_CFG_SVH

// ====================
// Address and data
// ====================

// Byte address width, shared by the front end and the memory
`define CACHE_BE_ADDR_W 16

// Width of one data word
`define CACHE_BE_DATA_W 32

// ====================
// Line and buffer
// ====================

// log2 of the number of words in one cache line
`define CACHE_BE_WORD_OFFSET_W 2

// Entries in the write-through buffer
`define CACHE_BE_WBUF_DEPTH 4

`endif

// ==== source/cache_be_pkg.sv ====
`include "cache_be_cfg.svh"

package cache_be_pkg;

   // ====================
   // Word geometry
   // ====================

   // Bytes per data word and the width of a byte offset
   localparam int NBYTES = `CACHE_BE_DATA_W / 8;
   localparam int NBYTES_W = $clog2(NBYTES);

   // ====================
   // Line geometry
   // ====================

   localparam int LINE_WORDS = 2 ** `CACHE_BE_WORD_OFFSET_W;

   // Word addresses drop the byte offset, line addresses also drop the word offset
   localparam int WORD_ADDR_W = `CACHE_BE_ADDR_W - NBYTES_W;
   localparam int LINE_ADDR_W = WORD_ADDR_W - `CACHE_BE_WORD_OFFSET_W;

   // ====================
   // Write buffer
   // ====================

   // Pointer width, kept at one bit for a single-entry buffer
   localparam int WBUF_PTR_W = (`CACHE_BE_WBUF_DEPTH > 1) ?
                               $clog2(`CACHE_BE_WBUF_DEPTH) : 1;

   // The occupancy count must be able to hold the full depth
   localparam int WBUF_CNT_W = $clog2(`CACHE_BE_WBUF_DEPTH + 1);

endpackage

// ==== source/mem_port_if.sv ====
`include "cache_be_cfg.svh"

interface mem_port_if;
   import cache_be_pkg::*;

   // Request side
   logic                        valid;
   logic [WORD_ADDR_W-1:0]      addr;
   logic [`CACHE_BE_DATA_W-1:0] wdata;
   logic [NBYTES-1:0]           wstrb;

   // Response side, rdata is valid together with ready
   logic [`CACHE_BE_DATA_W-1:0] rdata;
   logic                        ready;

   // The requester drives the request and waits for ready
   modport channel (
      output valid, addr, wdata, wstrb,
      input  rdata, ready
   );

   // The responder answers a request
   modport back_end (
      input  valid, addr, wdata, wstrb,
      output rdata, ready
   );

endinterface

// ==== source/write_through_buffer.sv ====
`include "cache_be_cfg.svh"

module write_through_buffer (
   input  logic                                 clk_i,
   input  logic                                 reset_i,

   input  logic                                 push_valid_i,
   input  logic [cache_be_pkg::WORD_ADDR_W-1:0] push_addr_i,
   input  logic [`CACHE_BE_DATA_W-1:0]          push_wdata_i,
   input  logic [cache_be_pkg::NBYTES-1:0]      push_wstrb_i,
   output logic                                 push_ready_o,

   input  logic                                 pop_i,
   output logic                                 head_valid_o,
   output logic [cache_be_pkg::WORD_ADDR_W-1:0] head_addr_o,
   output logic [`CACHE_BE_DATA_W-1:0]          head_wdata_o,
   output logic [cache_be_pkg::NBYTES-1:0]      head_wstrb_o,

   output logic                                 pending_o
);
   import cache_be_pkg::*;

   localparam int DEPTH = `CACHE_BE_WBUF_DEPTH;

   // Entry storage
   logic [WORD_ADDR_W-1:0]      addr_mem  [DEPTH];
   logic [`CACHE_BE_DATA_W-1:0] wdata_mem [DEPTH];
   logic [NBYTES-1:0]           wstrb_mem [DEPTH];

   logic [WBUF_PTR_W-1:0] wr_ptr_q;
   logic [WBUF_PTR_W-1:0] rd_ptr_q;
   logic [WBUF_CNT_W-1:0] count_q;
   logic                  push;

   assign push_ready_o = (count_q != WBUF_CNT_W'(DEPTH));
   assign push         = push_valid_i & push_ready_o;

   assign head_valid_o = (count_q != '0);
   assign pending_o    = head_valid_o;
   assign head_addr_o  = addr_mem[rd_ptr_q];
   assign head_wdata_o = wdata_mem[rd_ptr_q];
   assign head_wstrb_o = wstrb_mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (push) begin
         addr_mem[wr_ptr_q]  <= push_addr_i;
         wdata_mem[wr_ptr_q] <= push_wdata_i;
         wstrb_mem[wr_ptr_q] <= push_wstrb_i;
      end
   end

   // Pointers wrap at the depth, which need not be a power of two
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == WBUF_PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= (rd_ptr_q == WBUF_PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({push, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // The write channel must only take an entry that is there
   a_no_pop_when_empty: assert property (
      @(posedge clk_i) disable iff (reset_i) pop_i |-> head_valid_o
   );

   a_count_in_range: assert property (
      @(posedge clk_i) disable iff (reset_i) count_q <= WBUF_CNT_W'(DEPTH)
   );

endmodule

// ==== source/write_channel.sv ====
`include "cache_be_cfg.svh"

module write_channel (
   input  logic                                 clk_i,
   input  logic                                 reset_i,

   input  logic                                 head_valid_i,
   input  logic [cache_be_pkg::WORD_ADDR_W-1:0] head_addr_i,
   input  logic [`CACHE_BE_DATA_W-1:0]          head_wdata_i,
   input  logic [cache_be_pkg::NBYTES-1:0]      head_wstrb_i,
   output logic                                 pop_o,

   output logic                                 busy_o,

   mem_port_if.channel                          mem
);
   import cache_be_pkg::*;

   localparam logic ST_IDLE  = 1'b0;
   localparam logic ST_WRITE = 1'b1;

   logic                        state_q;
   logic [WORD_ADDR_W-1:0]      addr_q;
   logic [`CACHE_BE_DATA_W-1:0] wdata_q;
   logic [NBYTES-1:0]           wstrb_q;

   // The head is taken as soon as the channel is free
   assign pop_o  = (state_q == ST_IDLE) & head_valid_i;
   assign busy_o = (state_q == ST_WRITE);

   assign mem.valid = busy_o;
   assign mem.addr  = addr_q;
   assign mem.wdata = wdata_q;
   assign mem.wstrb = wstrb_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (head_valid_i) begin
                  state_q <= ST_WRITE;
               end
            end
            default: begin
               if (mem.ready) begin
                  state_q <= ST_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         addr_q  <= head_addr_i;
         wdata_q <= head_wdata_i;
         wstrb_q <= head_wstrb_i;
      end
   end

   // A stalled write keeps its request until the memory completes it
   a_stable_under_stall: assert property (
      @(posedge clk_i) disable iff (reset_i)
      (mem.valid && !mem.ready) |=>
         (mem.valid && $stable(mem.addr) && $stable(mem.wdata) && $stable(mem.wstrb))
   );

endmodule

// ==== source/read_channel.sv ====
`include "cache_be_cfg.svh"

module read_channel (
   input  logic                                 clk_i,
   input  logic                                 reset_i,

   input  logic                                 start_i,
   input  logic [cache_be_pkg::LINE_ADDR_W-1:0] line_addr_i,
   output logic                                 replace_o,

   output logic                                 read_valid_o,
   output logic [`CACHE_BE_WORD_OFFSET_W-1:0]   read_addr_o,
   output logic [`CACHE_BE_DATA_W-1:0]          read_rdata_o,

   mem_port_if.channel                          mem
);
   import cache_be_pkg::*;

   localparam int OFFSET_W = `CACHE_BE_WORD_OFFSET_W;

   // ====================
   // Refill states
   // ====================

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_READ = 2'd1;
   localparam logic [1:0] ST_DONE = 2'd2;

   logic [1:0]             state_q;
   logic [OFFSET_W-1:0]    offset_q;
   logic [LINE_ADDR_W-1:0] line_q;
   logic                   word_done;
   logic                   last_word;

   assign word_done = mem.valid & mem.ready;
   assign last_word = (offset_q == OFFSET_W'(LINE_WORDS - 1));

   // Replace covers the whole refill plus one closing cycle
   assign replace_o = (state_q != ST_IDLE);

   // One read per word, reads never carry a strobe
   assign mem.valid = (state_q == ST_READ);
   assign mem.addr  = {line_q, offset_q};
   assign mem.wdata = '0;
   assign mem.wstrb = '0;

   // Each word goes out in the cycle the memory returns it
   assign read_valid_o = word_done;
   assign read_addr_o  = offset_q;
   assign read_rdata_o = mem.rdata;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q  <= ST_IDLE;
         offset_q <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               offset_q <= '0;
               if (start_i) begin
                  state_q <= ST_READ;
               end
            end
            ST_READ: begin
               if (word_done) begin
                  if (last_word) begin
                     state_q  <= ST_DONE;
                     offset_q <= '0;
                  end else begin
                     offset_q <= offset_q + 1'b1;
                  end
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i && state_q == ST_IDLE) begin
         line_q <= line_addr_i;
      end
   end

   // The back end must route ready only to the channel that asked
   a_no_ready_without_request: assert property (
      @(posedge clk_i) disable iff (reset_i) mem.ready |-> mem.valid
   );

endmodule

// ==== source/cache_back_end.sv ====
`include "cache_be_cfg.svh"

module cache_back_end (
   input  logic                                 clk_i,
   input  logic                                 reset_i,

   input  logic                                 head_valid_i,
   input  logic [cache_be_pkg::WORD_ADDR_W-1:0] head_addr_i,
   input  logic [`CACHE_BE_DATA_W-1:0]          head_wdata_i,
   input  logic [cache_be_pkg::NBYTES-1:0]      head_wstrb_i,
   output logic                                 pop_o,
   input  logic                                 writes_pending_i,

   input  logic                                 replace_valid_i,
   input  logic [cache_be_pkg::LINE_ADDR_W-1:0] replace_addr_i,
   output logic                                 replace_o,
   output logic                                 read_valid_o,
   output logic [`CACHE_BE_WORD_OFFSET_W-1:0]   read_addr_o,
   output logic [`CACHE_BE_DATA_W-1:0]          read_rdata_o,

   mem_port_if.channel                          mem
);

   mem_port_if rd_if ();
   mem_port_if wr_if ();

   logic wr_busy;
   logic refill_start;
   logic wr_head_valid;

   // A refill waits until every buffered write has reached memory
   assign refill_start  = replace_valid_i & ~writes_pending_i & ~wr_busy & ~replace_o;

   // New writes stay in the buffer while a refill owns the port
   assign wr_head_valid = head_valid_i & ~replace_o;

   read_channel u_read_channel (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .start_i      (refill_start),
      .line_addr_i  (replace_addr_i),
      .replace_o    (replace_o),
      .read_valid_o (read_valid_o),
      .read_addr_o  (read_addr_o),
      .read_rdata_o (read_rdata_o),
      .mem          (rd_if)
   );

   write_channel u_write_channel (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .head_valid_i (wr_head_valid),
      .head_addr_i  (head_addr_i),
      .head_wdata_i (head_wdata_i),
      .head_wstrb_i (head_wstrb_i),
      .pop_o        (pop_o),
      .busy_o       (wr_busy),
      .mem          (wr_if)
   );

   // ====================
   // Port arbitration
   // ====================

   // Reads win the port
   assign mem.valid = rd_if.valid | wr_if.valid;
   assign mem.addr  = rd_if.valid ? rd_if.addr  : wr_if.addr;
   assign mem.wdata = rd_if.valid ? rd_if.wdata : wr_if.wdata;
   assign mem.wstrb = rd_if.valid ? rd_if.wstrb : wr_if.wstrb;

   assign rd_if.ready = mem.ready & rd_if.valid;
   assign wr_if.ready = mem.ready & wr_if.valid & ~rd_if.valid;
   assign rd_if.rdata = mem.rdata;
   assign wr_if.rdata = mem.rdata;

   a_single_requester: assert property (
      @(posedge clk_i) disable iff (reset_i) !(rd_if.valid && wr_if.valid)
   );

endmodule

// ==== source/cache_back_end_top.sv ====
`include "cache_be_cfg.svh"

module cache_back_end_top (
   input  logic                                 clk_i,
   input  logic                                 reset_i,

   // Front-end word writes
   input  logic                                 write_valid_i,
   input  logic [cache_be_pkg::WORD_ADDR_W-1:0] write_addr_i,
   input  logic [`CACHE_BE_DATA_W-1:0]          write_wdata_i,
   input  logic [cache_be_pkg::NBYTES-1:0]      write_wstrb_i,
   output logic                                 write_ready_o,

   // Line replacement
   input  logic                                 replace_valid_i,
   input  logic [cache_be_pkg::LINE_ADDR_W-1:0] replace_addr_i,
   output logic                                 replace_o,
   output logic                                 read_valid_o,
   output logic [`CACHE_BE_WORD_OFFSET_W-1:0]   read_addr_o,
   output logic [`CACHE_BE_DATA_W-1:0]          read_rdata_o,

   // Word memory
   output logic                                 mem_valid_o,
   output logic [cache_be_pkg::WORD_ADDR_W-1:0] mem_addr_o,
   output logic [`CACHE_BE_DATA_W-1:0]          mem_wdata_o,
   output logic [cache_be_pkg::NBYTES-1:0]      mem_wstrb_o,
   input  logic [`CACHE_BE_DATA_W-1:0]          mem_rdata_i,
   input  logic                                 mem_ready_i
);
   import cache_be_pkg::*;

   logic                        head_valid;
   logic [WORD_ADDR_W-1:0]      head_addr;
   logic [`CACHE_BE_DATA_W-1:0] head_wdata;
   logic [NBYTES-1:0]           head_wstrb;
   logic                        head_pop;
   logic                        writes_pending;

   mem_port_if mem_if ();

   write_through_buffer u_write_buffer (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .push_valid_i (write_valid_i),
      .push_addr_i  (write_addr_i),
      .push_wdata_i (write_wdata_i),
      .push_wstrb_i (write_wstrb_i),
      .push_ready_o (write_ready_o),
      .pop_i        (head_pop),
      .head_valid_o (head_valid),
      .head_addr_o  (head_addr),
      .head_wdata_o (head_wdata),
      .head_wstrb_o (head_wstrb),
      .pending_o    (writes_pending)
   );

   cache_back_end u_back_end (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .head_valid_i     (head_valid),
      .head_addr_i      (head_addr),
      .head_wdata_i     (head_wdata),
      .head_wstrb_i     (head_wstrb),
      .pop_o            (head_pop),
      .writes_pending_i (writes_pending),
      .replace_valid_i  (replace_valid_i),
      .replace_addr_i   (replace_addr_i),
      .replace_o        (replace_o),
      .read_valid_o     (read_valid_o),
      .read_addr_o      (read_addr_o),
      .read_rdata_o     (read_rdata_o),
      .mem              (mem_if)
   );

   assign mem_valid_o  = mem_if.valid;
   assign mem_addr_o   = mem_if.addr;
   assign mem_wdata_o  = mem_if.wdata;
   assign mem_wstrb_o  = mem_if.wstrb;
   assign mem_if.rdata = mem_rdata_i;
   assign mem_if.ready = mem_ready_i;

endmodule

// ==== verification/tb_memory_model.sv ====
`include "cache_be_cfg.svh"

module tb_memory_model (
   input  logic                                 clk_i,
   input  logic                                 reset_i,
   input  logic                                 hold_i,
   input  logic                                 mem_valid_i,
   input  logic [cache_be_pkg::WORD_ADDR_W-1:0] mem_addr_i,
   input  logic [`CACHE_BE_DATA_W-1:0]          mem_wdata_i,
   input  logic [cache_be_pkg::NBYTES-1:0]      mem_wstrb_i,
   output logic [`CACHE_BE_DATA_W-1:0]          mem_rdata_o,
   output logic                                 mem_ready_o
);
   timeunit 1ns;
   timeprecision 100ps;
   import cache_be_pkg::*;

   logic [`CACHE_BE_DATA_W-1:0] words [2**WORD_ADDR_W];
   logic [31:0]                 rng_q;
   logic [1:0]                  stall_q;
   logic                        waiting_q;

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Odd multiplier, so every word address gets its own start value
   function automatic logic [31:0] fill_word(input logic [WORD_ADDR_W-1:0] addr);
      return (32'(addr) * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
   endfunction

   initial begin
      for (int i = 0; i < 2**WORD_ADDR_W; i++) begin
         words[i] = fill_word(WORD_ADDR_W'(i));
      end
   end

   assign mem_rdata_o = words[mem_addr_i];

   // Each request waits 0 to 3 extra cycles; hold_i freezes a waiting request
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rng_q       <= 32'd9;
         stall_q     <= '0;
         waiting_q   <= 1'b0;
         mem_ready_o <= 1'b0;
      end else if (mem_ready_o) begin
         mem_ready_o <= 1'b0;
      end else if (waiting_q) begin
         if (!hold_i) begin
            if (stall_q == '0) begin
               mem_ready_o <= 1'b1;
               waiting_q   <= 1'b0;
            end else begin
               stall_q <= stall_q - 1'b1;
            end
         end
      end else if (mem_valid_i) begin
         rng_q     <= next_random(rng_q);
         stall_q   <= rng_q[1:0];
         waiting_q <= 1'b1;
      end
   end

   always @(posedge clk_i) begin
      if (mem_valid_i && mem_ready_o && mem_wstrb_i != '0) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (mem_wstrb_i[b]) begin
               words[mem_addr_i][8*b +: 8] = mem_wdata_i[8*b +: 8];
            end
         end
      end
   end

endmodule

// ==== verification/tb_cache_back_end.sv ====
`include "cache_be_cfg.svh"

module tb_cache_back_end;
   timeunit 1ns;
   timeprecision 100ps;
   import cache_be_pkg::*;

   localparam int DATA_W        = `CACHE_BE_DATA_W;
   localparam int OFF_W         = `CACHE_BE_WORD_OFFSET_W;
   localparam int REC_W         = WORD_ADDR_W + DATA_W + NBYTES;
   localparam int TIMEOUT       = 200;
   localparam int SIG_REPLACE   = 0;
   localparam int SIG_MEM_VALID = 1;

   logic                   clk = 1'b0;
   logic                   reset;
   logic                   hold;
   logic                   write_valid;
   logic [WORD_ADDR_W-1:0] write_addr;
   logic [DATA_W-1:0]      write_wdata;
   logic [NBYTES-1:0]      write_wstrb;
   logic                   write_ready;
   logic                   replace_valid;
   logic [LINE_ADDR_W-1:0] replace_addr;
   logic                   replace;
   logic                   read_valid;
   logic [OFF_W-1:0]       read_addr;
   logic [DATA_W-1:0]      read_rdata;
   logic                   mem_valid;
   logic [WORD_ADDR_W-1:0] mem_addr;
   logic [DATA_W-1:0]      mem_wdata;
   logic [NBYTES-1:0]      mem_wstrb;
   logic [DATA_W-1:0]      mem_rdata;
   logic                   mem_ready;

   // Expected memory contents and the writes seen on the memory port
   logic [DATA_W-1:0]      shadow [2**WORD_ADDR_W];
   logic [REC_W-1:0]       mem_log [$];
   logic [LINE_ADDR_W-1:0] refill_addr;
   logic [31:0]            rng = 32'd9;
   int                     words_seen;
   int                     errors;
   int                     errors_before;
   int                     checks;
   int                     tests;
   bit                     aborted;

   always #2 clk = ~clk;

   cache_back_end_top uut (
      .clk_i           (clk),
      .reset_i         (reset),
      .write_valid_i   (write_valid),
      .write_addr_i    (write_addr),
      .write_wdata_i   (write_wdata),
      .write_wstrb_i   (write_wstrb),
      .write_ready_o   (write_ready),
      .replace_valid_i (replace_valid),
      .replace_addr_i  (replace_addr),
      .replace_o       (replace),
      .read_valid_o    (read_valid),
      .read_addr_o     (read_addr),
      .read_rdata_o    (read_rdata),
      .mem_valid_o     (mem_valid),
      .mem_addr_o      (mem_addr),
      .mem_wdata_o     (mem_wdata),
      .mem_wstrb_o     (mem_wstrb),
      .mem_rdata_i     (mem_rdata),
      .mem_ready_i     (mem_ready)
   );

   tb_memory_model u_memory (
      .clk_i       (clk),
      .reset_i     (reset),
      .hold_i      (hold),
      .mem_valid_i (mem_valid),
      .mem_addr_i  (mem_addr),
      .mem_wdata_i (mem_wdata),
      .mem_wstrb_i (mem_wstrb),
      .mem_rdata_o (mem_rdata),
      .mem_ready_o (mem_ready)
   );

   // ====================
   // Reference model
   // ====================

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [DATA_W-1:0] fill_word(input logic [WORD_ADDR_W-1:0] addr);
      return (32'(addr) * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
   endfunction

   function automatic logic [DATA_W-1:0] merge_strobes(input logic [DATA_W-1:0] old_word,
                                                       input logic [DATA_W-1:0] new_word,
                                                       input logic [NBYTES-1:0] strb);
      logic [DATA_W-1:0] result;
      result = old_word;
      for (int b = 0; b < NBYTES; b++) begin
         if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
      end
      return result;
   endfunction

   function automatic logic [DATA_W-1:0] expected_word(input logic [LINE_ADDR_W-1:0] line,
                                                       input logic [OFF_W-1:0] offset);
      return shadow[{line, offset}];
   endfunction

   task automatic compare_value(input logic [31:0] expected, input logic [31:0] actual,
                                input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Mismatch at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
      end
   endtask

   // The scoreboard samples every output on the falling edge
   always @(negedge clk) begin
      if (!reset) begin
         if (write_valid && write_ready) begin
            shadow[write_addr] = merge_strobes(shadow[write_addr], write_wdata, write_wstrb);
         end
         if (mem_valid && mem_ready && mem_wstrb != '0) begin
            mem_log.push_back({mem_addr, mem_wdata, mem_wstrb});
         end
         if (read_valid) begin
            compare_value(32'(words_seen), 32'(read_addr), "read_addr_o order");
            compare_value(32'({refill_addr, OFF_W'(words_seen)}), 32'(mem_addr),
                          "refill read address");
            compare_value(0, 32'(mem_wstrb), "refill read strobe");
            compare_value(expected_word(refill_addr, OFF_W'(words_seen)), read_rdata,
                          "refill word");
            compare_value(1, 32'(replace), "replace_o while words return");
            words_seen++;
         end
      end
   end

   // ====================
   // Stimulus tasks
   // ====================

   task automatic report_timeout(input string what);
      aborted = 1'b1;
      $display("Timeout at %0t ns: %s within %0d cycles", $time, what, TIMEOUT);
   endtask

   task automatic wait_for(input int sig, input logic level, input string what);
      int n;
      n = 0;
      @(negedge clk);
      while (((sig == SIG_REPLACE) ? replace : mem_valid) !== level && !aborted) begin
         n++;
         if (n > TIMEOUT) report_timeout(what);
         else @(negedge clk);
      end
   endtask

   task automatic wait_mem_writes(input int count);
      int n;
      n = 0;
      @(negedge clk);
      while (mem_log.size() < count && !aborted) begin
         n++;
         if (n > TIMEOUT) report_timeout("buffered writes did not reach memory");
         else @(negedge clk);
      end
      @(posedge clk);
      #1;
   endtask

   task automatic push_write(input logic [WORD_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [NBYTES-1:0] strb);
      int n;
      n = 0;
      write_valid = 1'b1;
      write_addr  = addr;
      write_wdata = data;
      write_wstrb = strb;
      @(negedge clk);
      while (!write_ready && !aborted) begin
         n++;
         if (n > TIMEOUT) report_timeout("write_ready_o stayed low");
         else @(negedge clk);
      end
      @(posedge clk);
      #1;
      write_valid = 1'b0;
   endtask

   task automatic expect_mem_write(input logic [WORD_ADDR_W-1:0] addr,
                                   input logic [DATA_W-1:0] data, input logic [NBYTES-1:0] strb);
      logic [REC_W-1:0] rec;
      if (mem_log.size() == 0) begin
         errors++;
         $display("No memory write arrived for word address %h", addr);
         return;
      end
      rec = mem_log.pop_front();
      compare_value(32'(addr), 32'(rec[REC_W-1 -: WORD_ADDR_W]), "memory write address");
      compare_value(data, rec[NBYTES +: DATA_W], "memory write data");
      compare_value(32'(strb), 32'(rec[NBYTES-1:0]), "memory write strobe");
   endtask

   task automatic refill(input logic [LINE_ADDR_W-1:0] line);
      words_seen    = 0;
      refill_addr   = line;
      replace_valid = 1'b1;
      replace_addr  = line;
      wait_for(SIG_REPLACE, 1'b1, "replace_o never rose");
      @(posedge clk);
      #1;
      replace_valid = 1'b0;
      wait_for(SIG_REPLACE, 1'b0, "replace_o never fell");
      if (!aborted) compare_value(LINE_WORDS, words_seen, "words returned before replace_o fell");
      @(posedge clk);
      #1;
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("Test %0d, %s: %0d errors", tests, name, errors - errors_before);
      errors_before = errors;
   endtask

   // ====================
   // Tests
   // ====================

   task automatic write_partial_words();
      mem_log.delete();
      push_write(14'h0048, 32'h1122_3344, 4'b0011);
      push_write(14'h0049, 32'h5566_7788, 4'b1100);
      push_write(14'h004A, 32'h99AA_BBCC, 4'b0100);
      wait_mem_writes(3);
      expect_mem_write(14'h0048, 32'h1122_3344, 4'b0011);
      expect_mem_write(14'h0049, 32'h5566_7788, 4'b1100);
      expect_mem_write(14'h004A, 32'h99AA_BBCC, 4'b0100);
      refill(12'h012);
   endtask

   task automatic fill_buffer_under_stall();
      int accepted;
      accepted = 0;
      mem_log.delete();
      hold = 1'b1;
      // The first write parks in the write channel and the next ones fill the buffer
      push_write(14'h0200, 32'hC0DE_0000, 4'hF);
      wait_for(SIG_MEM_VALID, 1'b1, "the stalled write never reached the memory port");
      @(posedge clk);
      #1;
      write_valid = 1'b1;
      write_addr  = 14'h0201;
      write_wdata = 32'hC0DE_0001;
      write_wstrb = 4'hF;
      @(negedge clk);
      while (write_ready && accepted < 8) begin
         accepted++;
         @(posedge clk);
         #1;
         write_addr  = 14'h0201 + WORD_ADDR_W'(accepted);
         write_wdata = 32'hC0DE_0001 + 32'(accepted);
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      write_valid = 1'b0;
      hold = 1'b0;
      compare_value(`CACHE_BE_WBUF_DEPTH, accepted, "writes accepted under a stall");
      wait_mem_writes(5);
      for (int k = 0; k < 5; k++) begin
         expect_mem_write(14'h0200 + WORD_ADDR_W'(k), 32'hC0DE_0000 + 32'(k), 4'hF);
      end
   endtask

   task automatic refill_after_burst();
      for (int k = 0; k < LINE_WORDS; k++) begin
         push_write({12'h055, OFF_W'(k)}, 32'hB000_0000 + 32'(k), 4'hF);
      end
      push_write({12'h055, OFF_W'(1)}, 32'hEE00_0000, 4'b1000);
      refill(12'h055);
   endtask

   task automatic mix_random_traffic();
      logic [LINE_ADDR_W-1:0] line;
      logic [NBYTES-1:0]      strb;
      for (int step = 0; step < 60 && !aborted; step++) begin
         rng  = next_random(rng);
         line = {10'h020, rng[1:0]};
         strb = (rng[8:5] == '0) ? 4'hF : rng[8:5];
         if (rng[3:2] != 2'd0) begin
            push_write({line, rng[10:9]}, {rng[15:0], rng[31:16]} ^ 32'h0F0F_0F0F, strb);
         end else begin
            refill(line);
         end
      end
      refill(12'h080);
   endtask

   initial begin
      reset         = 1'b1;
      hold          = 1'b0;
      write_valid   = 1'b0;
      write_addr    = '0;
      write_wdata   = '0;
      write_wstrb   = '0;
      replace_valid = 1'b0;
      replace_addr  = '0;
      refill_addr   = '0;
      for (int i = 0; i < 2**WORD_ADDR_W; i++) begin
         shadow[i] = fill_word(WORD_ADDR_W'(i));
      end
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;

      @(negedge clk);
      compare_value(1, 32'(write_ready), "write_ready_o after reset");
      compare_value(0, 32'(mem_valid), "mem_valid_o after reset");
      compare_value(0, 32'(replace), "replace_o after reset");
      compare_value(0, 32'(read_valid), "read_valid_o after reset");
      @(posedge clk);
      #1;
      end_test("state after reset");

      if (!aborted) begin
         write_partial_words();
         end_test("partial strobe writes");
      end
      if (!aborted) begin
         fill_buffer_under_stall();
         end_test("back-pressure with a stalled memory");
      end
      if (!aborted) begin
         refill(12'h3A7);
         end_test("refill of an untouched line");
      end
      if (!aborted) begin
         refill_after_burst();
         end_test("refill right after a write burst");
      end
      if (!aborted) begin
         mix_random_traffic();
         end_test("random writes and refills");
      end

      $display("Summary: %0d tests, %0d checks, %0d errors, timeout %0d",
               tests, checks, errors, aborted);
      if (errors == 0 && !aborted) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+source
source/cache_be_pkg.sv
source/mem_port_if.sv
source/write_through_buffer.sv
source/write_channel.sv
source/read_channel.sv
source/cache_back_end.sv
source/cache_back_end_top.sv
verification/tb_memory_model.sv
verification/tb_cache_back_end.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the cache back-end testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
   --top-module tb_cache_back_end --Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_cache_back_end > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1
